// File: Makefile
# Verilator build and run of the radio control core testbench

VERILATOR ?= verilator
TOP       ?= u1e_core_tb
FILELIST  ?= u1e_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: cordic_rotator.sv
// Pipelined CORDIC rotator: turns the vector (x, y) by phase z, one iteration per stage
// Latency is stages plus one, a new sample enters every cycle; gain is about 1.647
`timescale 1ns/1ps

`include "u1e_macros.svh"

module cordic_rotator
  (input  logic                wb_clk,

   input  u1e_pkg::iq_sample_t x_i,
   input  u1e_pkg::iq_sample_t y_i,
   input  u1e_pkg::phase_t     z_i,

   output u1e_pkg::iq_sample_t x_o,
   output u1e_pkg::iq_sample_t y_o
   );

   import u1e_pkg::*;

   localparam int STAGES = `U1E_CORDIC_STAGES;
   localparam logic [24*STAGES-1:0] ATAN = `U1E_CORDIC_ATAN;

   // Inputs must leave headroom for the gain
   iq_sample_t x_q [0:STAGES];
   iq_sample_t y_q [0:STAGES];
   phase_t     z_q [0:STAGES];
   logic       fold;

   // Second and third quadrants lie outside the convergence range
   assign fold = z_i[23] ^ z_i[22];

   always_ff @(posedge wb_clk)
   begin
      ////////////////////////////////////////////////////////////////////////
      // Fold into the right half-plane by half a turn
      if (fold)
      begin
         x_q[0] <= -x_i;
         y_q[0] <= -y_i;
         z_q[0] <= {~z_i[23], z_i[22:0]};
      end
      else
      begin
         x_q[0] <= x_i;
         y_q[0] <= y_i;
         z_q[0] <= z_i;
      end

      ////////////////////////////////////////////////////////////////////////
      // Micro-rotations toward zero residual phase
      for (int i = 0; i < STAGES; i++)
      begin
         if (z_q[i][23])                            // Residual negative
         begin
            x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
            y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
            z_q[i+1] <= z_q[i] + ATAN[24*i +: 24];
         end
         else
         begin
            x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
            y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
            z_q[i+1] <= z_q[i] - ATAN[24*i +: 24];
         end
      end
   end

   assign x_o = x_q[STAGES];
   assign y_o = y_q[STAGES];

endmodule

// File: misc_regs.sv
// Slot 0 control and status registers: LEDs, clock generator control, tone frequency
// Acks every access in the strobe cycle, reads are combinational from registers and pins
`timescale 1ns/1ps

`include "u1e_macros.svh"

module misc_regs
  (input  logic             wb_clk,
   input  logic             wb_rst,

   input  logic             stb_i,
   input  logic             we_i,
   input  u1e_pkg::wb_adr_t adr_i,
   input  u1e_pkg::wb_dat_t dat_i,
   output u1e_pkg::wb_dat_t dat_o,
   output logic             ack_o,

   input  logic [7:0]       dip_sw_i,
   input  logic [2:0]       debug_pb_i,
   input  logic             cgen_st_status_i,
   input  logic             cgen_st_ld_i,
   input  logic             cgen_st_refmon_i,

   output logic [2:0]       debug_led_o,
   output logic             cgen_sync_b_o,
   output logic             cgen_ref_sel_o,
   output u1e_pkg::wb_dat_t tone_freq_o
   );

   import u1e_pkg::*;

   wb_dat_t reg_leds;
   wb_dat_t reg_cgen_ctrl;
   wb_dat_t reg_test;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= `U1E_CGEN_CTRL_RESET;
         reg_test      <= '0;
      end
      else if (stb_i && we_i)
      begin
         case (adr_i[6:0])
            `U1E_REG_LEDS      : reg_leds      <= dat_i;
            `U1E_REG_CGEN_CTRL : reg_cgen_ctrl <= dat_i;
            `U1E_REG_TEST      : reg_test      <= dat_i;
            default            : ;                    // Status offsets are read only
         endcase
      end
   end

   always_comb
   begin
      case (adr_i[6:0])
         `U1E_REG_LEDS      : dat_o = reg_leds;
         `U1E_REG_SWITCHES  : dat_o = {5'b0, debug_pb_i, dip_sw_i};
         `U1E_REG_CGEN_CTRL : dat_o = reg_cgen_ctrl;
         `U1E_REG_CGEN_ST   : dat_o = {13'b0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         `U1E_REG_TEST      : dat_o = reg_test;
         default            : dat_o = `U1E_READ_DEFAULT;
      endcase
   end

   assign ack_o = stb_i;

   // Board LED order: bit 2 to LED 1, bit 1 to LED 0, bit 0 to LED 2
   assign debug_led_o = {reg_leds[0], reg_leds[2], reg_leds[1]};

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign tone_freq_o    = reg_test;        // Upper bits of the phase increment

endmodule

// File: settings_bus_16le.sv
// Slot 5 bridge from 16-bit Wishbone writes to the 32-bit settings bus
// Low half first (address bit 1 clear), the high-half write fires a one-cycle strobe
`timescale 1ns/1ps

module settings_bus_16le
  (input  logic               wb_clk,
   input  logic               wb_rst,

   input  logic               stb_i,
   input  logic               we_i,
   input  u1e_pkg::wb_adr_t   adr_i,
   input  u1e_pkg::wb_dat_t   dat_i,
   output logic               ack_o,

   output logic               set_stb_o,
   output u1e_pkg::set_addr_t set_addr_o,
   output u1e_pkg::set_data_t set_data_o
   );

   import u1e_pkg::*;

   wb_dat_t   low_q;            // Held until the high half arrives
   set_addr_t addr_q;
   set_data_t data_q;
   logic      wr_low;
   logic      wr_high;

   assign wr_low  = stb_i & we_i & ~adr_i[1];
   assign wr_high = stb_i & we_i & adr_i[1];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_high;  // Exactly one cycle per high write
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_q <= dat_i;
      if (wr_high)
      begin
         addr_q <= {3'b0, adr_i[6:2]};  // 32 settings registers
         data_q <= {dat_i, low_q};
      end
   end

   assign ack_o      = stb_i;
   assign set_addr_o = addr_q;
   assign set_data_o = data_q;

endmodule

// File: tx_tone_gen.sv
// TX test tone: phase accumulator into the CORDIC, I and Q interleaved onto the DAC bus
// txsync low marks the I word, high marks the Q word
`timescale 1ns/1ps

`include "u1e_macros.svh"

module tx_tone_gen
  (input  logic               wb_clk,
   input  logic               wb_rst,

   input  u1e_pkg::wb_dat_t   tone_freq_i,

   output u1e_pkg::dac_word_t tx_o,
   output logic               txsync_o
   );

   import u1e_pkg::*;

   logic       tx_stb;          // High on I cycles
   phase_t     phase;
   phase_t     freq;
   iq_sample_t tx_i;
   iq_sample_t tx_q;
   dac_word_t  q_hold;

   assign freq = {tone_freq_i, 8'd0};

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         tx_stb   <= 1'b0;
         phase    <= '0;
         txsync_o <= 1'b0;
      end
      else
      begin
         tx_stb   <= ~tx_stb;
         txsync_o <= ~tx_stb;
         if (tx_stb)
            phase <= phase + freq;  // One step per I/Q pair
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // DAC interleave
   always_ff @(posedge wb_clk)
   begin
      if (tx_stb)
      begin
         tx_o   <= tx_i[23:10];
         q_hold <= tx_q[23:10];
      end
      else
         tx_o <= q_hold;
   end

   cordic_rotator tx_cordic
     (.wb_clk (wb_clk),
      .x_i    (iq_sample_t'(`U1E_TONE_AMPLITUDE)),
      .y_i    (iq_sample_t'(0)),
      .z_i    (phase),
      .x_o    (tx_i),
      .y_o    (tx_q));

endmodule

// File: u1e_core.f
+incdir+.
u1e_pkg.sv
wb_slave_decode.sv
misc_regs.sv
settings_bus_16le.sv
vita_time_64.sv
cordic_rotator.sv
tx_tone_gen.sv
u1e_core.sv
u1e_core_assert.sv
u1e_core_tb.sv

// File: u1e_core.sv
// Top of the radio control core, driven by an external 16-bit Wishbone master
// Slot 0 holds the misc registers, slot 5 the settings bus feeding the time counter
`timescale 1ns/1ps

module u1e_core
  (input  logic                wb_clk,
   input  logic                wb_rst,

   // Wishbone master port, full-word accesses only
   input  u1e_pkg::wb_adr_t    wb_adr_i,
   input  u1e_pkg::wb_dat_t    wb_dat_i,
   input  u1e_pkg::wb_sel_t    wb_sel_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   output u1e_pkg::wb_dat_t    wb_dat_o,
   output logic                wb_ack_o,

   input  logic [7:0]          dip_sw_i,
   input  logic [2:0]          debug_pb_i,
   input  logic                cgen_st_status_i,
   input  logic                cgen_st_ld_i,
   input  logic                cgen_st_refmon_i,
   input  logic                pps_i,

   output logic [2:0]          debug_led_o,
   output logic                cgen_sync_b_o,
   output logic                cgen_ref_sel_o,
   output u1e_pkg::dac_word_t  tx_o,
   output logic                txsync_o,
   output logic                txblank_o,
   output u1e_pkg::vita_time_t vita_time_o,
   output logic                pps_int_o
   );

   import u1e_pkg::*;

   logic      misc_stb, misc_ack;
   wb_dat_t   misc_dat;
   logic      s5_stb, s5_ack;
   wb_dat_t   tone_freq;
   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;

   assign txblank_o = 1'b0;     // DAC never blanked

   wb_slave_decode decode0
     (.adr_i(wb_adr_i), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
      .misc_stb_o(misc_stb), .misc_ack_i(misc_ack), .misc_dat_i(misc_dat),
      .set_stb_o(s5_stb), .set_ack_i(s5_ack), .dat_o(wb_dat_o), .ack_o(wb_ack_o));

   misc_regs misc0
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(misc_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .dat_o(misc_dat), .ack_o(misc_ack),
      .dip_sw_i(dip_sw_i), .debug_pb_i(debug_pb_i), .cgen_st_status_i(cgen_st_status_i),
      .cgen_st_ld_i(cgen_st_ld_i), .cgen_st_refmon_i(cgen_st_refmon_i),
      .debug_led_o(debug_led_o), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o), .tone_freq_o(tone_freq));

   tx_tone_gen tone0
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .tone_freq_i(tone_freq),
      .tx_o(tx_o), .txsync_o(txsync_o));

   settings_bus_16le settings0
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(s5_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i), .ack_o(s5_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   vita_time_64 time0
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

endmodule

// File: u1e_core_assert.sv
// Concurrent checks on the Wishbone handshake, the settings strobe and the DAC sync line
// Attached to every u1e_core instance by the bind at the end of this file
`timescale 1ns/1ps

module u1e_core_assert_checks
  (input logic wb_clk,
   input logic wb_rst,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic set_stb_i,
   input logic txsync_i
   );

   logic live_q;                        // Out of reset for a full cycle

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         live_q <= 1'b0;
      else
         live_q <= 1'b1;
   end

   ack_needs_request: assert property (@(posedge wb_clk) disable iff (wb_rst)
      ack_i |-> (stb_i && cyc_i))
   else $error("ack seen without stb and cyc");

   // Settings strobe is a single-cycle pulse
   set_stb_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_i |=> !set_stb_i)
   else $error("settings strobe held for two cycles");

   txsync_toggles: assert property (@(posedge wb_clk) disable iff (wb_rst)
      live_q |-> (txsync_i != $past(txsync_i)))
   else $error("txsync did not toggle");

endmodule

bind u1e_core u1e_core_assert_checks chk0
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
   .ack_i(wb_ack_o), .set_stb_i(set_stb), .txsync_i(txsync_o));

// File: u1e_core_tb.sv
// Directed testbench for the radio control core with Wishbone master tasks, time and tone checks
// Built and run through the Makefile target sim
`timescale 1ns/1ps

`include "u1e_macros.svh"

module u1e_core_tb;

   import u1e_pkg::*;

   localparam int          CLK_HALF       = 4;        // 8 ns period
   localparam int          ACK_LIMIT      = 16;
   localparam int          TIMEOUT_CYCLES = 20000;    // Whole run is about 1,000 cycles
   localparam int          STAGES         = `U1E_CORDIC_STAGES;
   localparam logic [31:0] TICKS_PER_SEC  = 32'd64000000;
   localparam logic [4:0]  SR_SECS        = 5'd0;
   localparam logic [4:0]  SR_TICKS       = 5'd1;
   localparam logic [4:0]  SR_CTRL        = 5'd2;
   // Gain 1.647 times amplitude, then 10 LSBs dropped onto the DAC
   localparam longint      TONE_I_EXPECT  = 64'sd1647 * 64'sd2500000 / 64'sd1024000;

   logic       wb_clk;
   logic       wb_rst;
   wb_adr_t    wb_adr;
   wb_dat_t    wb_dat_w;
   wb_sel_t    wb_sel;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   wb_dat_t    wb_dat_r;
   logic       wb_ack;
   logic [7:0] dip_sw;
   logic [2:0] debug_pb;
   logic       cgen_status;
   logic       cgen_ld;
   logic       cgen_refmon;
   logic       pps;
   logic [2:0] debug_led;
   logic       cgen_sync_b;
   logic       cgen_ref_sel;
   dac_word_t  tx;
   logic       txsync;
   logic       txblank;
   vita_time_t vita_time;
   logic       pps_int;

   logic [31:0] lcg_state = 32'd80;
   longint      zero_mag2;                // I^2 + Q^2 of the zero-frequency tone

   u1e_core dut0
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
      .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
      .dip_sw_i(dip_sw), .debug_pb_i(debug_pb), .cgen_st_status_i(cgen_status),
      .cgen_st_ld_i(cgen_ld), .cgen_st_refmon_i(cgen_refmon), .pps_i(pps),
      .debug_led_o(debug_led), .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel),
      .tx_o(tx), .txsync_o(txsync), .txblank_o(txblank),
      .vita_time_o(vita_time), .pps_int_o(pps_int));

   initial
   begin
      wb_clk = 1'b0;
      forever #CLK_HALF wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic abort_run(input string reason);
      $display("Error: %s", reason);
      $display("=== FAIL ===");
      $fatal(1, "run aborted");
   endtask

   task automatic check_true(input string what, input logic cond);
      assert (cond === 1'b1)
      else
         abort_run(what);
   endtask

   task automatic check_value(input string test, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
         abort_run($sformatf("%s: expected %0h, actual %0h", test, expected, actual));
   endtask

   task automatic check_near(input string test, input longint expected, input longint actual,
                             input longint tol);
      assert (((actual - expected) <= tol) && ((expected - actual) <= tol))
      else
         abort_run($sformatf("%s: expected %0d +/- %0d, actual %0d",
                             test, expected, tol, actual));
   endtask

   task automatic step_to_drive();
      @(posedge wb_clk);
      #1;                                // Inputs move just after the edge
   endtask

   task automatic reset_dut();
      wb_rst = 1'b1;
      repeat (5) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
   endtask

   function automatic wb_adr_t misc_adr(input logic [6:0] offset);
      return {4'd0, offset};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone master tasks enter and leave just after a rising edge
   task automatic wait_ack();
      int cycles;
      cycles = 0;
      @(negedge wb_clk);
      while (!wb_ack)
      begin
         cycles++;
         check_true("Wishbone slave gave no ack", cycles < ACK_LIMIT);
         @(negedge wb_clk);
      end
   endtask

   task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_we    = 1'b1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wait_ack();
      step_to_drive();                   // Write lands on this edge
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_read(input wb_adr_t adr, output wb_dat_t dat);
      wb_adr = adr;
      wb_we  = 1'b0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wait_ack();
      dat = wb_dat_r;
      step_to_drive();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic read_check(input string test, input wb_adr_t adr, input wb_dat_t expected);
      wb_dat_t rd;
      bus_read(adr, rd);
      check_value(test, 64'(expected), 64'(rd));
   endtask

   // Low half first so the high half fires the settings strobe
   task automatic settings_write(input logic [4:0] set_reg, input logic [31:0] data);
      bus_write({4'd5, set_reg, 2'b00}, data[15:0]);
      bus_write({4'd5, set_reg, 2'b10}, data[31:16]);
   endtask

   task automatic capture_pair(output longint i_val, output longint q_val);
      logic signed [13:0] w;
      @(negedge wb_clk);
      if (txsync)
         @(negedge wb_clk);
      w = tx;
      i_val = longint'(w);
      @(negedge wb_clk);
      check_true("txsync was not high on the Q word", txsync);
      w = tx;
      q_val = longint'(w);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   task automatic test_misc_regs();
      wb_dat_t v;
      logic [2:0] exp_led;
      step_to_drive();
      check_value("reset led pins", 64'd0, 64'(debug_led));
      check_value("reset cgen sync", 64'd1, 64'(cgen_sync_b));
      check_value("reset cgen ref", 64'd1, 64'(cgen_ref_sel));
      read_check("reset leds", misc_adr(`U1E_REG_LEDS), 16'd0);
      read_check("reset cgen ctrl", misc_adr(`U1E_REG_CGEN_CTRL), 16'd3);

      v = 16'(next_rand());
      bus_write(misc_adr(`U1E_REG_LEDS), v);
      read_check("leds readback", misc_adr(`U1E_REG_LEDS), v);
      exp_led[1] = v[2];                 // Board order
      exp_led[0] = v[1];
      exp_led[2] = v[0];
      check_value("led pins", 64'(exp_led), 64'(debug_led));

      v = 16'(next_rand());
      bus_write(misc_adr(`U1E_REG_CGEN_CTRL), v);
      read_check("cgen ctrl readback", misc_adr(`U1E_REG_CGEN_CTRL), v);
      check_value("cgen sync pin", 64'(v[1]), 64'(cgen_sync_b));
      check_value("cgen ref pin", 64'(v[0]), 64'(cgen_ref_sel));

      v = 16'(next_rand());
      bus_write(misc_adr(`U1E_REG_TEST), v);
      read_check("test readback", misc_adr(`U1E_REG_TEST), v);
   endtask

   task automatic test_readback();
      logic [31:0] r;
      step_to_drive();
      r = next_rand();
      dip_sw      = r[7:0];
      debug_pb    = r[10:8];
      cgen_status = r[11];
      cgen_ld     = r[12];
      cgen_refmon = r[13];
      read_check("switches", misc_adr(`U1E_REG_SWITCHES), {5'b0, r[10:8], r[7:0]});
      read_check("cgen status", misc_adr(`U1E_REG_CGEN_ST), {13'b0, r[11], r[12], r[13]});
      read_check("unmapped offset", misc_adr(7'd10), 16'hBEEF);
   endtask

   task automatic test_time_load_now();
      logic [31:0] secs;
      logic [31:0] ticks;
      logic [31:0] prev;
      int waited;
      step_to_drive();
      secs  = next_rand() | 32'h0000_1000;
      ticks = next_rand() & 32'h00FF_FFFF;   // Far below the wrap
      settings_write(SR_SECS, secs);
      settings_write(SR_TICKS, ticks);
      settings_write(SR_CTRL, 32'd1);
      waited = 0;
      @(negedge wb_clk);
      while (vita_time[63:32] != secs)
      begin
         waited++;
         check_true("immediate time load never happened", waited < 8);
         @(negedge wb_clk);
      end
      check_true("ticks below the loaded value", vita_time[31:0] >= ticks);
      check_true("ticks too far past the loaded value", vita_time[31:0] <= ticks + 32'd4);
      prev = vita_time[31:0];
      repeat (10)
      begin
         @(negedge wb_clk);
         check_value("load now seconds", 64'(secs), 64'(vita_time[63:32]));
         check_value("load now ticks", 64'(prev + 32'd1), 64'(vita_time[31:0]));
         prev = vita_time[31:0];
      end
   endtask

   task automatic test_wrap_and_pps();
      logic [31:0] secs;
      logic [31:0] ticks;
      vita_time_t  prev_time;
      int waited;
      step_to_drive();
      secs = next_rand() | 32'h0000_1000;
      settings_write(SR_SECS, secs);
      settings_write(SR_TICKS, TICKS_PER_SEC - 32'd3);
      settings_write(SR_CTRL, 32'd1);
      waited = 0;
      @(negedge wb_clk);
      prev_time = vita_time;
      @(negedge wb_clk);
      while (vita_time != {secs + 32'd1, 32'd0})
      begin
         prev_time = vita_time;
         waited++;
         check_true("ticks never wrapped into the next second", waited < 16);
         @(negedge wb_clk);
      end
      check_value("last tick before wrap", {secs, TICKS_PER_SEC - 32'd1}, prev_time);

      // Arm a PPS load and keep PPS low for a while
      step_to_drive();
      secs  = next_rand() | 32'h0000_1000;
      ticks = next_rand() & 32'h00FF_FFFF;
      settings_write(SR_SECS, secs);
      settings_write(SR_TICKS, ticks);
      settings_write(SR_CTRL, 32'd0);
      repeat (4) @(negedge wb_clk);
      check_true("time loaded without a PPS edge", vita_time[63:32] != secs);
      step_to_drive();
      pps = 1'b1;
      waited = 0;
      @(negedge wb_clk);
      while (!pps_int)
      begin
         check_true("time loaded before the PPS pulse", vita_time[63:32] != secs);
         waited++;
         check_true("no PPS pulse after raising pps_i", waited < 8);
         @(negedge wb_clk);
      end
      @(negedge wb_clk);
      check_value("PPS load", {secs, ticks}, vita_time);
      step_to_drive();
      pps = 1'b0;
   endtask

   task automatic test_tone_zero();
      longint i_val;
      longint q_val;
      step_to_drive();
      reset_dut();                       // Phase and frequency back to 0
      repeat (STAGES + 6) @(posedge wb_clk);
      capture_pair(i_val, q_val);
      check_near("tone zero I", TONE_I_EXPECT, i_val, 64'sd8);
      check_near("tone zero Q", 64'sd0, q_val, 64'sd8);
      check_value("tone zero txblank", 64'd0, 64'(txblank));
      zero_mag2 = i_val * i_val + q_val * q_val;
   endtask

   task automatic test_tone_nonzero();
      wb_dat_t freq;
      longint  i_val;
      longint  q_val;
      longint  prev_i;
      longint  prev_q;
      int      changes;
      step_to_drive();
      freq = (16'(next_rand()) & 16'h0FFF) | 16'h0100;
      bus_write(misc_adr(`U1E_REG_TEST), freq);
      repeat (STAGES + 6) @(posedge wb_clk);
      changes = 0;
      prev_i  = 0;
      prev_q  = 0;
      for (int n = 0; n < 64; n++)
      begin
         capture_pair(i_val, q_val);
         check_near("tone magnitude squared", zero_mag2, i_val * i_val + q_val * q_val,
                    zero_mag2 / 64'sd100);
         check_value("tone txblank", 64'd0, 64'(txblank));
         if ((n > 0) && ((i_val != prev_i) || (q_val != prev_q)))
            changes++;
         prev_i = i_val;
         prev_q = q_val;
      end
      check_true("tone samples never changed", changes > 0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   initial
   begin
      wb_rst      = 1'b1;
      wb_adr      = '0;
      wb_dat_w    = '0;
      wb_sel      = 2'b11;               // Full-word accesses
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      dip_sw      = '0;
      debug_pb    = '0;
      cgen_status = 1'b0;
      cgen_ld     = 1'b0;
      cgen_refmon = 1'b0;
      pps         = 1'b0;
      reset_dut();
      test_misc_regs();
      test_readback();
      test_time_load_now();
      test_wrap_and_pps();
      test_tone_zero();
      test_tone_nonzero();
      $display("=== PASS ===");
      $finish;
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge wb_clk);
      abort_run("watchdog expired before the tests finished");
   end

endmodule

// File: u1e_macros.svh
// Bus widths, address map, register offsets and tone path constants for the radio core
// Included by the package and by any module that decodes addresses or sizes the datapath
`ifndef U1E_MACROS_SVH
`define U1E_MACROS_SVH

`define U1E_DW 16                   // Wishbone data width
`define U1E_AW 11                   // Byte address width
`define U1E_SW 2                    // Select width

// Slot numbers, taken from address bits 10 to 7
`define U1E_SLOT_MISC     4'd0
`define U1E_SLOT_SETTINGS 4'd5

// Misc register byte offsets, address bits 6 to 0
`define U1E_REG_LEDS      7'd0
`define U1E_REG_SWITCHES  7'd2
`define U1E_REG_CGEN_CTRL 7'd4
`define U1E_REG_CGEN_ST   7'd6
`define U1E_REG_TEST      7'd8

`define U1E_READ_DEFAULT    16'hBEEF
`define U1E_CGEN_CTRL_RESET 16'd3    // Sync deasserted, reference select high

`define U1E_SR_TIME64     8'd0
`define U1E_TICKS_PER_SEC 32'd64000000

`define U1E_CORDIC_STAGES  20
`define U1E_TONE_AMPLITUDE 24'd2500000

// Arctangent of 2^-i in phase units (2^24 per circle), entry i at bits [24*i +: 24]
`define U1E_CORDIC_ATAN { \
   24'd5,      24'd10,     24'd20,     24'd41,     24'd81, \
   24'd163,    24'd326,    24'd652,    24'd1304,   24'd2608, \
   24'd5215,   24'd10430,  24'd20860,  24'd41718,  24'd83416, \
   24'd166669, 24'd332050, 24'd654136, 24'd1238021, 24'd2097152 }

`endif

// File: u1e_pkg.sv
// Shared bus, settings, sample and time types of the radio core
// Imported by every module of the design

`include "u1e_macros.svh"

package u1e_pkg;

   // Wishbone side
   typedef logic [`U1E_AW-1:0] wb_adr_t;    // Byte address
   typedef logic [`U1E_DW-1:0] wb_dat_t;
   typedef logic [`U1E_SW-1:0] wb_sel_t;

   // Settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Tone path
   typedef logic [23:0]        phase_t;      // Full circle is 2^24
   typedef logic signed [23:0] iq_sample_t;
   typedef logic [13:0]        dac_word_t;

   typedef logic [63:0] vita_time_t;         // Seconds high, ticks low

endpackage

// File: vita_time_64.sv
// 64-bit VITA time: seconds above ticks, set over the settings bus
// A load is armed by the control register and happens at once or at the next PPS edge
`timescale 1ns/1ps

`include "u1e_macros.svh"

module vita_time_64
  (input  logic                wb_clk,
   input  logic                wb_rst,

   input  logic                set_stb_i,
   input  u1e_pkg::set_addr_t  set_addr_i,
   input  u1e_pkg::set_data_t  set_data_i,

   input  logic                pps_i,
   output u1e_pkg::vita_time_t vita_time_o,
   output logic                pps_int_o
   );

   import u1e_pkg::*;

   vita_time_t pend_q;          // Time to load
   vita_time_t time_q;
   logic       armed;
   logic       load_now;        // Mode flag, clear waits for PPS
   logic [1:0] pps_sync;
   logic       pps_dly;
   logic       pps_edge;
   logic       do_load;

   assign pps_edge = pps_sync[1] & ~pps_dly;
   assign do_load  = armed & (load_now | pps_edge);

   ////////////////////////////////////////////////////////////////////////////
   // Settings registers
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == `U1E_SR_TIME64))
         pend_q[63:32] <= set_data_i;
      if (set_stb_i && (set_addr_i == `U1E_SR_TIME64 + 8'd1))
         pend_q[31:0] <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         armed    <= 1'b0;
         load_now <= 1'b0;
      end
      else if (set_stb_i && (set_addr_i == `U1E_SR_TIME64 + 8'd2))
      begin
         armed    <= 1'b1;
         load_now <= set_data_i[0];
      end
      else if (do_load)
         armed <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= 2'b00;
         pps_dly  <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_dly  <= pps_sync[1];
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         time_q <= '0;
      else if (do_load)
         time_q <= pend_q;
      else if (time_q[31:0] == `U1E_TICKS_PER_SEC - 32'd1)
      begin
         time_q[31:0]  <= '0;                       // Second boundary
         time_q[63:32] <= time_q[63:32] + 32'd1;
      end
      else
         time_q[31:0] <= time_q[31:0] + 32'd1;
   end

   assign vita_time_o = time_q;
   assign pps_int_o   = pps_edge;

endmodule

// File: wb_slave_decode.sv
// Single-master Wishbone address decoder for the sixteen slave slots
// Gates the master strobe onto the selected slot and returns that slot's ack and read data
`timescale 1ns/1ps

`include "u1e_macros.svh"

module wb_slave_decode
  (input  u1e_pkg::wb_adr_t adr_i,
   input  logic             cyc_i,
   input  logic             stb_i,

   // Slot 0, misc registers
   output logic             misc_stb_o,
   input  logic             misc_ack_i,
   input  u1e_pkg::wb_dat_t misc_dat_i,

   // Slot 5, settings bus
   output logic             set_stb_o,
   input  logic             set_ack_i,

   output u1e_pkg::wb_dat_t dat_o,
   output logic             ack_o
   );

   import u1e_pkg::*;

   logic [3:0] slot;
   logic       bus_req;

   assign slot    = adr_i[10:7];
   assign bus_req = stb_i & cyc_i;

   assign misc_stb_o = bus_req & (slot == `U1E_SLOT_MISC);
   assign set_stb_o  = bus_req & (slot == `U1E_SLOT_SETTINGS);

   // Slaves ack only on their own strobe, empty slots never answer
   assign ack_o = misc_ack_i | set_ack_i;

   // Settings slot is write only
   assign dat_o = (slot == `U1E_SLOT_MISC) ? misc_dat_i : wb_dat_t'(0);

endmodule
